//--- logic/msx_control.sv
//==================================================
// MSX control glue
// Menu status decode, core reset combine, tape
// rewind pulse and cassette audio source select
//==================================================

`timescale 1ns/100ps
`default_nettype none

module msx_control
   import msx_pkg::*;
(
   input  wire logic                clk21m,
   input  wire logic                reset,
   input  wire logic [STATUS_W-1:0] status,
   input  wire logic                forced_scandoubler,
   input  wire logic                ioctl_download,
   input  wire logic [15:0]         ioctl_index,
   input  wire logic                core_req,
   input  wire logic                cas_file_bit,
   input  wire logic                tape_adc,
   input  wire logic                tape_adc_act,
   output msx_cfg_t                 cfg,
   output logic                     core_reset,
   output logic                     tape_rewind,
   output logic                     cas_audio_in
);

   // Cassette image being downloaded
   logic cas_download;

   // Any reset source this cycle
   logic reset_src;

   // Any rewind source this cycle
   logic rewind_src;

   //==================================================
   // Status decode
   //==================================================

   always_comb begin
      cfg.aspect    = aspect_e'(status[ST_ASPECT_LO +: 2]);
      cfg.scanlines = status[ST_SCANLINES_LO +: 2];
      cfg.scale     = status[ST_SCALE_LO +: 2];
      cfg.vcrop_en  = status[ST_VCROP];
      // Scanlines need the doubled picture too
      cfg.scandoubler = forced_scandoubler | (|status[ST_SCANLINES_LO +: 2]);
      cfg.tape_src  = tape_src_e'(status[ST_TAPE_SRC]);
   end

   //==================================================
   // Reset and rewind
   //==================================================

   // Only the low 6 bits carry the file type index
   assign cas_download = ioctl_download &&
                         (ioctl_index[5:0] == 6'(CAS_IOCTL_INDEX));

   // Menu reset, reset with detach, or a core request
   assign reset_src  = status[ST_RESET] | status[ST_DETACH] | core_req;

   // Rewind on menu request or fresh CAS image
   assign rewind_src = status[ST_REWIND] | cas_download;

   // Board reset also resets core and rewinds the tape
   always_ff @(posedge clk21m) begin
      if (reset) begin
         core_reset  <= 1'b1;
         tape_rewind <= 1'b1;
      end else begin
         core_reset  <= reset_src;
         tape_rewind <= rewind_src;
      end
   end

   //==================================================
   // Cassette audio
   //==================================================

   // ADC bit is only valid while the ADC sees a signal
   assign cas_audio_in = (cfg.tape_src == tape_file) ? cas_file_bit
                                                     : (tape_adc & tape_adc_act);

endmodule

`default_nettype wire

//--- logic/msx_glue.sv
//==================================================
// MSX board glue top level
// Control decode, HDMI crop and SD routing blocks
//==================================================

`timescale 1ns/100ps
`default_nettype none

module msx_glue
   import msx_pkg::*;
(
   input  wire logic                clk21m,
   input  wire logic                reset,
   // Host menu and download
   input  wire logic [STATUS_W-1:0] status,
   input  wire logic                forced_scandoubler,
   input  wire logic                ioctl_download,
   input  wire logic [15:0]         ioctl_index,
   // Core and cassette
   input  wire logic                core_req,
   input  wire logic                cas_file_bit,
   input  wire logic                tape_adc,
   input  wire logic                tape_adc_act,
   // HDMI output mode
   input  wire hdmi_res_t           hdmi,
   // SD image and SPI
   input  wire logic                img_mounted,
   input  wire logic [31:0]         img_size,
   input  wire logic                spi_ss,
   input  wire logic                spi_clk,
   input  wire logic                spi_mosi,
   input  wire logic                sd_miso,
   input  wire logic                virt_miso,
   // Outputs
   output msx_cfg_t                 cfg,
   output logic                     core_reset,
   output logic                     tape_rewind,
   output logic                     cas_audio_in,
   output crop_t                    crop,
   output sd_pins_t                 sd_pins,
   output logic                     spi_miso,
   output logic                     virt_ss,
   output logic                     sd_act
);

   // Menu decode, resets and tape
   msx_control i_control (
      .clk21m             (clk21m),
      .reset              (reset),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .ioctl_download     (ioctl_download),
      .ioctl_index        (ioctl_index),
      .core_req           (core_req),
      .cas_file_bit       (cas_file_bit),
      .tape_adc           (tape_adc),
      .tape_adc_act       (tape_adc_act),
      .cfg                (cfg),
      .core_reset         (core_reset),
      .tape_rewind        (tape_rewind),
      .cas_audio_in       (cas_audio_in)
   );

   // Crop follows the decoded config
   video_crop i_crop (
      .clk21m (clk21m),
      .reset  (reset),
      .cfg    (cfg),
      .hdmi   (hdmi),
      .crop   (crop)
   );

   // Slot or image card
   sd_route i_sd (
      .clk21m      (clk21m),
      .reset       (reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_ss      (spi_ss),
      .spi_clk     (spi_clk),
      .spi_mosi    (spi_mosi),
      .sd_miso     (sd_miso),
      .virt_miso   (virt_miso),
      .sd_pins     (sd_pins),
      .spi_miso    (spi_miso),
      .virt_ss     (virt_ss),
      .sd_act      (sd_act)
   );

endmodule

`default_nettype wire

//--- logic/msx_pkg.sv
//==================================================
// MSX glue shared definitions
// Menu status bit map, config types, crop and SD
// pin bundles used by the board-level glue logic
//==================================================

`default_nettype none

package msx_pkg;

   //==================================================
   // Widths and constants
   //==================================================

   // Menu status word from the host
   localparam int STATUS_W = 64;

   // Status bit positions
   localparam int ST_RESET        = 0;
   localparam int ST_ASPECT_LO    = 1;
   localparam int ST_SCANLINES_LO = 3;
   localparam int ST_SCALE_LO     = 5;
   localparam int ST_VCROP        = 7;
   localparam int ST_TAPE_SRC     = 8;
   localparam int ST_REWIND       = 9;
   localparam int ST_DETACH       = 10;

   // Download index of a CAS image
   localparam int CAS_IOCTL_INDEX = 5;

   // Idle cycles until the SD activity LED goes dark
   localparam int SD_ACT_CYCLES = 1024;

   // HDMI resolution, crop and aspect field widths
   localparam int HDMI_W = 12;
   localparam int CROP_W = 10;
   localparam int AR_W   = 12;

   //==================================================
   // Enums
   //==================================================

   // Menu aspect ratio choice
   typedef enum logic [1:0] {
      ar_original = 2'd0,
      ar_full     = 2'd1,
      ar_custom1  = 2'd2,
      ar_custom2  = 2'd3
   } aspect_e;

   // Cassette input source
   typedef enum logic {
      tape_file = 1'b0,
      tape_adc  = 1'b1
   } tape_src_e;

   //==================================================
   // Structs
   //==================================================

   // Decoded menu configuration
   typedef struct packed {
      aspect_e   aspect;
      logic [1:0] scanlines;
      logic [1:0] scale;
      logic       vcrop_en;
      logic       scandoubler;
      tape_src_e  tape_src;
   } msx_cfg_t;

   // HDMI output resolution
   typedef struct packed {
      logic [HDMI_W-1:0] width;
      logic [HDMI_W-1:0] height;
   } hdmi_res_t;

   // Scaler crop and aspect settings
   typedef struct packed {
      logic [CROP_W-1:0] crop_size;
      logic [AR_W-1:0]   arx;
      logic [AR_W-1:0]   ary;
   } crop_t;

   // Physical SD slot pins
   typedef struct packed {
      logic cs;
      logic sck;
      logic mosi;
   } sd_pins_t;

endpackage

`default_nettype wire

//--- logic/sd_route.sv
//==================================================
// SD card routing
// Switches SPI between the physical slot and the
// virtual image card, with an activity timer
//==================================================

`timescale 1ns/100ps
`default_nettype none

module sd_route
   import msx_pkg::*;
(
   input  wire logic        clk21m,
   input  wire logic        reset,
   input  wire logic        img_mounted,
   input  wire logic [31:0] img_size,
   input  wire logic        spi_ss,
   input  wire logic        spi_clk,
   input  wire logic        spi_mosi,
   input  wire logic        sd_miso,
   input  wire logic        virt_miso,
   output sd_pins_t         sd_pins,
   output logic             spi_miso,
   output logic             virt_ss,
   output logic             sd_act
);

   // Virtual card selected
   logic vsd_sel;

   // Previous line levels for edge detect
   logic old_mosi;
   logic old_miso;

   // Edge on either data line
   logic line_edge;

   // Cycles since last edge, stops at the limit
   logic [$clog2(SD_ACT_CYCLES+1)-1:0] act_timer;

   //==================================================
   // Source select
   //==================================================

   // Mounting an empty image falls back to the slot
   always_ff @(posedge clk21m) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Park the physical slot while the image is used
   assign sd_pins.cs   = spi_ss | vsd_sel;
   assign sd_pins.sck  = spi_clk & ~vsd_sel;
   assign sd_pins.mosi = spi_mosi & ~vsd_sel;

   // Virtual card deselected when the slot is active
   assign virt_ss  = spi_ss | ~vsd_sel;
   assign spi_miso = vsd_sel ? virt_miso : sd_miso;

   //==================================================
   // Activity timer
   //==================================================

   always_ff @(posedge clk21m) begin
      old_mosi <= spi_mosi;
      old_miso <= spi_miso;
   end

   assign line_edge = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   always_ff @(posedge clk21m) begin
      if (reset) begin
         act_timer <= '0;
         sd_act    <= 1'b0;
      end else begin
         sd_act <= 1'b0;
         if (act_timer < SD_ACT_CYCLES) begin
            act_timer <= act_timer + 1'b1;
            sd_act    <= 1'b1;
         end
         // Any traffic restarts the window
         if (line_edge) begin
            act_timer <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/video_crop.sv
//==================================================
// HDMI vertical crop and aspect select
// Picks crop height from the output resolution and
// the aspect ratio sent to the scaler, registered
//==================================================

`timescale 1ns/100ps
`default_nettype none

module video_crop
   import msx_pkg::*;
(
   input  wire logic      clk21m,
   input  wire logic      reset,
   input  wire msx_cfg_t  cfg,
   input  wire hdmi_res_t hdmi,
   output crop_t          crop
);

   // Height plus half the height, one bit wider
   logic [HDMI_W:0]   h_plus_half;

   // Output at least 1.5 times wider than tall
   logic              is_wide;

   // Looked-up crop height before the enable
   logic [CROP_W-1:0] crop_lut;

   // 16:10 class output, narrow the picture
   logic              wide;

   // Next register value
   crop_t             crop_nxt;

   //==================================================
   // Crop lookup
   //==================================================

   assign h_plus_half = {1'b0, hdmi.height} + (HDMI_W+1)'(hdmi.height[HDMI_W-1:1]);
   assign is_wide     = {1'b0, hdmi.width} >= h_plus_half;

   always_comb begin
      crop_lut = '0;
      wide     = 1'b0;
      // Doubled output is never cropped
      if (!cfg.scandoubler) begin
         if (is_wide) begin
            case (hdmi.height)
               HDMI_W'(480),
               HDMI_W'(720),
               HDMI_W'(1200),
               HDMI_W'(1440): crop_lut = CROP_W'(240);
               HDMI_W'(600),
               HDMI_W'(800): begin
                  crop_lut = CROP_W'(200);
                  wide     = cfg.vcrop_en;
               end
               // NTSC shows about 250 lines here
               HDMI_W'(768):  crop_lut = CROP_W'(256);
               HDMI_W'(1080): crop_lut = CROP_W'(216);
               default:       crop_lut = '0;
            endcase
         end else if (hdmi.width >= HDMI_W'(1440)) begin
            // 4:3 modes too tall for the wide test
            case (hdmi.height)
               HDMI_W'(1440): crop_lut = CROP_W'(240);
               HDMI_W'(1536): crop_lut = CROP_W'(256);
               default:       crop_lut = '0;
            endcase
         end
      end
   end

   //==================================================
   // Aspect ratio
   //==================================================

   always_comb begin
      crop_nxt.crop_size = cfg.vcrop_en ? crop_lut : '0;
      if (cfg.aspect == ar_original) begin
         // 4:3, or narrowed for the cropped wide modes
         crop_nxt.arx = wide ? AR_W'(340) : AR_W'(400);
         crop_nxt.ary = AR_W'(300);
      end else begin
         // Scaler reads 0..2 as full or custom presets
         crop_nxt.arx = AR_W'(cfg.aspect) - AR_W'(1);
         crop_nxt.ary = '0;
      end
   end

   // Output register
   always_ff @(posedge clk21m) begin
      if (reset) begin
         crop <= '0;
      end else begin
         crop <= crop_nxt;
      end
   end

endmodule

`default_nettype wire

//--- msx_glue.f
logic/msx_pkg.sv
logic/msx_control.sv
logic/video_crop.sv
logic/sd_route.sv
logic/msx_glue.sv
tests/msx_glue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the msx_glue testbench with Verilator
cd "$(dirname "$0")" \
&& verilator --binary --timing -j 0 --top-module msx_glue_tb \
   -f msx_glue.f -o msx_glue_sim \
&& ./obj_dir/msx_glue_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
&& echo "Simulation PASSED" \
|| { echo "Simulation FAILED"; exit 1; }

//--- tests/msx_glue_tb.sv
//==================================================
// MSX glue testbench
// Crop table, aspect, config decode, resets, SD
// routing and SD activity against reference models
//==================================================

`timescale 1ns/100ps
`default_nettype none

module msx_glue_tb
   import msx_pkg::*;
;

   // Run limit, well above the sum of all tests
   localparam int TIMEOUT_CYCLES = 5000;

   logic                clk21m;
   logic                reset;
   logic [STATUS_W-1:0] status;
   logic                forced_scandoubler;
   logic                ioctl_download;
   logic [15:0]         ioctl_index;
   logic                core_req;
   logic                cas_file_bit;
   logic                tape_adc;
   logic                tape_adc_act;
   hdmi_res_t           hdmi;
   logic                img_mounted;
   logic [31:0]         img_size;
   logic                spi_ss;
   logic                spi_clk;
   logic                spi_mosi;
   logic                sd_miso;
   logic                virt_miso;
   msx_cfg_t            cfg;
   logic                core_reset;
   logic                tape_rewind;
   logic                cas_audio_in;
   crop_t               crop;
   sd_pins_t            sd_pins;
   logic                spi_miso;
   logic                virt_ss;
   logic                sd_act;

   // Scoreboard
   int          errors;
   int          checks;
   int          tests;
   int          test_err_start;
   string       test_name;
   logic [31:0] rng_state;
   int          cycles;

   msx_glue i_dut (.*);

   // 4 ns clock
   initial begin
      clk21m = 1'b0;
      forever #2 clk21m = ~clk21m;
   end

   //==================================================
   // Random source and reference models
   //==================================================

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Menu word to config
   function automatic msx_cfg_t expect_cfg(input logic [63:0] st, input logic fsd);
      msx_cfg_t c;
      c.aspect      = aspect_e'(st[2:1]);
      c.scanlines   = st[4:3];
      c.scale       = st[6:5];
      c.vcrop_en    = st[7];
      c.scandoubler = fsd || (st[4:3] != 2'b00);
      c.tape_src    = tape_src_e'(st[8]);
      return c;
   endfunction

   function automatic logic expect_cas(input msx_cfg_t c, input logic file_bit,
                                       input logic adc_bit, input logic adc_act);
      return (c.tape_src == tape_file) ? file_bit : (adc_bit & adc_act);
   endfunction

   // Crop height table and aspect rule
   function automatic crop_t expect_crop(input msx_cfg_t c, input hdmi_res_t r);
      int    w;
      int    h;
      int    lut;
      logic  narrow;
      crop_t e;
      w      = r.width;
      h      = r.height;
      lut    = 0;
      narrow = 1'b0;
      if (!c.scandoubler) begin
         if (w >= h + h / 2) begin
            if (h == 480 || h == 720 || h == 1200 || h == 1440) lut = 240;
            else if (h == 600 || h == 800) begin
               lut    = 200;
               narrow = c.vcrop_en;
            end
            else if (h == 768) lut = 256;
            else if (h == 1080) lut = 216;
         end else if (w >= 1440) begin
            if (h == 1440) lut = 240;
            else if (h == 1536) lut = 256;
         end
      end
      e.crop_size = c.vcrop_en ? CROP_W'(lut) : '0;
      if (c.aspect == ar_original) begin
         e.arx = narrow ? AR_W'(340) : AR_W'(400);
         e.ary = AR_W'(300);
      end else begin
         e.arx = AR_W'(int'(c.aspect) - 1);
         e.ary = '0;
      end
      return e;
   endfunction

   function automatic logic expect_core_reset(input logic rst, input logic [63:0] st,
                                              input logic req);
      return rst | st[0] | st[10] | req;
   endfunction

   function automatic logic expect_rewind(input logic rst, input logic [63:0] st,
                                          input logic dl, input logic [15:0] idx);
      return rst | st[9] | (dl && idx[5:0] == 6'd5);
   endfunction

   function automatic sd_pins_t expect_pins(input logic vsd, input logic ss,
                                            input logic sclk, input logic mosi);
      sd_pins_t p;
      p.cs   = ss | vsd;
      p.sck  = sclk & ~vsd;
      p.mosi = mosi & ~vsd;
      return p;
   endfunction

   //==================================================
   // Compare tasks
   //==================================================

   task automatic check_crop(input crop_t got, input crop_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s crop got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_cfg(input msx_cfg_t got, input msx_cfg_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s cfg got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_pins(input sd_pins_t got, input sd_pins_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s pins got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      test_err_start = errors;
      tests++;
   endtask

   task automatic finish_test();
      int n;
      n = errors - test_err_start;
      $display("Test %s: %s, %0d errors", test_name, (n == 0) ? "ok" : "FAILED", n);
   endtask

   //==================================================
   // Tests
   //==================================================

   task automatic run_crop_table();
      int heights[10] = '{480, 600, 720, 768, 800, 1080, 1200, 1440, 1536, 500};
      int widths[6]   = '{640, 1024, 1280, 1440, 1920, 2560};
      start_test("crop table");
      for (int hi = 0; hi < 10; hi++) begin
         for (int wi = 0; wi < 6; wi++) begin
            // Bit 0 is vcrop, bit 1 is forced scandoubler
            for (int m = 0; m < 4; m++) begin
               @(posedge clk21m);
               status             <= {56'd0, m[0], 7'd0};
               forced_scandoubler <= m[1];
               hdmi               <= {12'(widths[wi]), 12'(heights[hi])};
               repeat (2) @(posedge clk21m);
               @(negedge clk21m);
               check_crop(crop, expect_crop(expect_cfg(status, forced_scandoubler), hdmi),
                          "crop table");
            end
         end
      end
      // Cropped 16:10 mode, 200 lines narrowed to 340
      @(posedge clk21m);
      status             <= 64'h80;
      forced_scandoubler <= 1'b0;
      hdmi               <= {12'd1280, 12'd800};
      repeat (2) @(posedge clk21m);
      @(negedge clk21m);
      check_crop(crop, {10'd200, 12'd340, 12'd300}, "1280x800 crop");
      finish_test();
   endtask

   task automatic run_aspect();
      logic [63:0] st;
      start_test("aspect");
      for (int a = 0; a < 4; a++) begin
         for (int k = 0; k < 3; k++) begin
            st      = {next_rand(), next_rand()};
            st[2:1] = 2'(a);
            @(posedge clk21m);
            status <= st;
            hdmi   <= {12'd1024, 12'd600};
            repeat (2) @(posedge clk21m);
            @(negedge clk21m);
            check_crop(crop, expect_crop(expect_cfg(status, forced_scandoubler), hdmi),
                       "aspect");
         end
      end
      finish_test();
   endtask

   task automatic run_config();
      logic [31:0] r;
      start_test("config decode");
      for (int i = 0; i < 200; i++) begin
         r = next_rand();
         @(posedge clk21m);
         status             <= {next_rand(), next_rand()};
         forced_scandoubler <= r[0];
         cas_file_bit       <= r[1];
         tape_adc           <= r[2];
         tape_adc_act       <= r[3];
         @(negedge clk21m);
         check_cfg(cfg, expect_cfg(status, forced_scandoubler), "decode");
         check_bit(cas_audio_in, expect_cas(expect_cfg(status, forced_scandoubler),
                   cas_file_bit, tape_adc, tape_adc_act), "cas_audio_in");
      end
      finish_test();
   endtask

   // One cycle of reset and rewind sources, outputs checked a cycle later
   task automatic apply_ctrl(input logic rst, input logic [63:0] st, input logic req,
                             input logic dl, input logic [15:0] idx, input string what);
      @(posedge clk21m);
      reset          <= rst;
      status         <= st;
      core_req       <= req;
      ioctl_download <= dl;
      ioctl_index    <= idx;
      @(posedge clk21m);
      @(negedge clk21m);
      check_bit(core_reset, expect_core_reset(rst, st, req), {what, " core_reset"});
      check_bit(tape_rewind, expect_rewind(rst, st, dl, idx), {what, " tape_rewind"});
   endtask

   task automatic run_resets();
      start_test("resets");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b0, 16'd0, "no source");
      apply_ctrl(1'b0, 64'h1, 1'b0, 1'b0, 16'd0, "menu reset");
      apply_ctrl(1'b0, 64'h400, 1'b0, 1'b0, 16'd0, "detach");
      apply_ctrl(1'b0, 64'h0, 1'b1, 1'b0, 16'd0, "core request");
      apply_ctrl(1'b1, 64'h0, 1'b0, 1'b0, 16'd0, "board reset");
      apply_ctrl(1'b0, 64'h200, 1'b0, 1'b0, 16'd0, "rewind bit");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b1, 16'd5, "cas download");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b1, 16'h0045, "cas download upper index");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b1, 16'd6, "other download");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b0, 16'd5, "index only");
      apply_ctrl(1'b0, 64'h0, 1'b0, 1'b0, 16'd0, "all clear");
      finish_test();
   endtask

   // Random SPI traffic against the expected card select
   task automatic sd_traffic(input logic vsd, input int n);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         r = next_rand();
         @(posedge clk21m);
         spi_ss    <= r[0];
         spi_clk   <= r[1];
         spi_mosi  <= r[2];
         sd_miso   <= r[3];
         virt_miso <= r[4];
         @(negedge clk21m);
         check_pins(sd_pins, expect_pins(vsd, spi_ss, spi_clk, spi_mosi), "sd pins");
         check_bit(virt_ss, spi_ss | ~vsd, "virt_ss");
         check_bit(spi_miso, vsd ? virt_miso : sd_miso, "spi_miso");
      end
   endtask

   task automatic mount(input logic [31:0] size);
      @(posedge clk21m);
      img_mounted <= 1'b1;
      img_size    <= size;
      @(posedge clk21m);
      img_mounted <= 1'b0;
   endtask

   task automatic run_sd_route();
      start_test("sd routing");
      sd_traffic(1'b0, 8);
      mount(32'h0010_0000);
      sd_traffic(1'b1, 8);
      mount(32'h0);
      sd_traffic(1'b0, 8);
      finish_test();
   endtask

   task automatic run_sd_activity();
      start_test("sd activity");
      @(posedge clk21m);
      reset     <= 1'b1;
      spi_mosi  <= 1'b0;
      sd_miso   <= 1'b0;
      virt_miso <= 1'b0;
      repeat (4) @(posedge clk21m);
      reset <= 1'b0;
      @(negedge clk21m);
      check_bit(sd_act, 1'b0, "sd_act in reset");
      repeat (2) @(posedge clk21m);
      @(negedge clk21m);
      check_bit(sd_act, 1'b1, "sd_act after reset");
      // Slow mosi traffic keeps the window open well past its length
      for (int i = 0; i < 12; i++) begin
         repeat (100) @(posedge clk21m);
         spi_mosi <= ~spi_mosi;
         @(negedge clk21m);
         check_bit(sd_act, 1'b1, "sd_act with traffic");
      end
      repeat (SD_ACT_CYCLES - 2) @(posedge clk21m);
      @(negedge clk21m);
      check_bit(sd_act, 1'b1, "sd_act near window end");
      repeat (5) @(posedge clk21m);
      @(negedge clk21m);
      check_bit(sd_act, 1'b0, "sd_act after idle");
      finish_test();
   endtask

   //==================================================
   // Main sequence and watchdog
   //==================================================

   initial begin
      errors    = 0;
      checks    = 0;
      tests     = 0;
      rng_state = 32'hc164eede;
      reset              <= 1'b1;
      status             <= '0;
      forced_scandoubler <= 1'b0;
      ioctl_download     <= 1'b0;
      ioctl_index        <= '0;
      core_req           <= 1'b0;
      cas_file_bit       <= 1'b0;
      tape_adc           <= 1'b0;
      tape_adc_act       <= 1'b0;
      hdmi               <= '0;
      img_mounted        <= 1'b0;
      img_size           <= '0;
      spi_ss             <= 1'b1;
      spi_clk            <= 1'b0;
      spi_mosi           <= 1'b0;
      sd_miso            <= 1'b0;
      virt_miso          <= 1'b0;
      repeat (16) @(posedge clk21m);
      reset <= 1'b0;
      run_crop_table();
      run_aspect();
      run_config();
      run_resets();
      run_sd_route();
      run_sd_activity();
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk21m);
         cycles++;
      end
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire
